// ==== common/ahb_defs.svh ====
////////////////////
// bus widths and limits shared by the master and its testbench.
// data width must be a power of two of at least 8 bits.
// the boundary is given as log2 of its size in bytes.
////////////////////

`ifndef AHB_DEFS_SVH
`define AHB_DEFS_SVH

`define AHB_ADDR_WIDTH    32
`define AHB_DATA_WIDTH    32

// wait cycles in one data phase before the beat is failed.
`define AHB_WAIT_TIMEOUT  6

`define AHB_BOUND_BITS    10    // 1 KB.

`endif

// ==== common/ahb_pkg.sv ====
////////////////////
// AHB-Lite field encodings and bus vector types.
// BUSY is listed for completeness, the master never drives it.
////////////////////

`include "ahb_defs.svh"

package ahb_pkg;

    typedef logic [`AHB_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AHB_DATA_WIDTH-1:0] data_t;
    typedef logic [2:0]                 size_t;    // log2 of bytes per beat.

    typedef enum logic [2:0] {
        BURST_SINGLE = 3'd0,
        BURST_INCR   = 3'd1,
        BURST_WRAP4  = 3'd2,
        BURST_INCR4  = 3'd3,
        BURST_WRAP8  = 3'd4,
        BURST_INCR8  = 3'd5,
        BURST_WRAP16 = 3'd6,
        BURST_INCR16 = 3'd7
    } burst_e;

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'd0,
        TRANS_BUSY   = 2'd1,
        TRANS_NONSEQ = 2'd2,
        TRANS_SEQ    = 2'd3
    } trans_e;

    // beats in a fixed-length burst, INCR counts as one.
    function automatic int unsigned burst_len(burst_e burst);
        case (burst)
            BURST_WRAP4, BURST_INCR4:   return 4;
            BURST_WRAP8, BURST_INCR8:   return 8;
            BURST_WRAP16, BURST_INCR16: return 16;
            default:                    return 1;
        endcase
    endfunction

endpackage

// ==== common/master_pkg.sv ====
////////////////////
// internal types of the burst master.
// a command is atomic and is never edited once taken.
////////////////////

package master_pkg;

    import ahb_pkg::*;

    // one checked client command.
    typedef struct packed {
        addr_t  addr;
        burst_e burst;
        size_t  size;
        logic   write;
    } cmd_t;

    // address-phase sequencer.
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // no burst.
        ST_ADDR  = 2'd1,    // an address phase is on the bus.
        ST_DRAIN = 2'd2     // waiting for the last response.
    } seq_state_e;

endpackage

// ==== common/cmd_if.sv ====
////////////////////
// checked command from the request check to the sequencer.
// valid is a one-cycle pulse, reject qualifies it.
////////////////////

`timescale 1ns/10ps

interface cmd_if
    import master_pkg::*;
();

    logic valid;
    cmd_t cmd;
    logic reject;    // command failed the check, no bus activity.
    logic busy;      // burst in progress, held until its last response.

    modport src (
        output valid,
        output cmd,
        output reject,
        input  busy
    );

    modport dst (
        input  valid,
        input  cmd,
        input  reject,
        output busy
    );

endinterface

// ==== common/beat_if.sv ====
////////////////////
// per-beat events between the sequencer and the data phase.
// accept, reject, abort and done are one-cycle pulses.
// abort is combinational in the cycle the failing beat ends.
////////////////////

`timescale 1ns/10ps

interface beat_if;

    logic accept;    // address phase taken this cycle.
    logic write;
    logic last;      // accepted beat closes the burst.
    logic reject;
    logic abort;
    logic done;      // final response of the burst is out.

    modport seq (
        output accept,
        output write,
        output last,
        output reject,
        input  abort,
        input  done
    );

    modport dat (
        input  accept,
        input  write,
        input  last,
        input  reject,
        output abort,
        output done
    );

endinterface

// ==== design/req_check.sv ====
////////////////////
// registers one client command and checks it against the bus rules.
// undefined-length INCR bursts are always rejected.
// wrap bursts stay inside their aligned block, so only INCRx is
// checked for a 1 KB crossing.
////////////////////

`timescale 1ns/10ps

`include "ahb_defs.svh"

module req_check
    import ahb_pkg::*;
    import master_pkg::*;
(
    input  logic    ahb_clk_in,
    input  logic    ahb_rstn_in,
    input  logic    cmd_valid,
    input  addr_t   cmd_addr,
    input  burst_e  cmd_burst,
    input  size_t   cmd_size,
    input  logic    cmd_write,
    output logic    cmd_busy,
    cmd_if.src      cmd
);

    logic  take;
    logic  size_ok;
    logic  align_ok;
    logic  cross_bad;
    logic  legal;
    addr_t align_mask;
    addr_t end_addr;

    assign cmd_busy = cmd.valid | cmd.busy;    // covers the pulse cycle too.
    assign take     = cmd_valid & ~cmd_busy;

    assign size_ok    = (32'd8 << cmd_size) <= `AHB_DATA_WIDTH;
    assign align_mask = (addr_t'(1) << cmd_size) - addr_t'(1);
    assign align_ok   = (cmd_addr & align_mask) == '0;

    // last byte touched by an incrementing burst.
    assign end_addr  = cmd_addr + (addr_t'(burst_len(cmd_burst)) << cmd_size) - addr_t'(1);
    assign cross_bad = (cmd_burst inside {BURST_INCR4, BURST_INCR8, BURST_INCR16}) &&
                       (end_addr[`AHB_ADDR_WIDTH-1:`AHB_BOUND_BITS] !=
                        cmd_addr[`AHB_ADDR_WIDTH-1:`AHB_BOUND_BITS]);

    assign legal = size_ok & align_ok & ~cross_bad & (cmd_burst != BURST_INCR);

    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            cmd.valid  <= 1'b0;
            cmd.reject <= 1'b0;
        end else begin
            cmd.valid <= take;
            if (take) begin
                cmd.reject <= ~legal;
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (take) begin
            cmd.cmd <= cmd_t'{addr: cmd_addr, burst: cmd_burst, size: cmd_size,
                              write: cmd_write};
        end
    end

endmodule

// ==== burst_seq/burst_seq.sv ====
////////////////////
// address-phase FSM, NONSEQ on the first beat and SEQ after.
// address and control hold while hready is low.
// on abort htrans drops to IDLE at once, even inside a wait state.
////////////////////

`timescale 1ns/10ps

module burst_seq
    import ahb_pkg::*;
    import master_pkg::*;
(
    input  logic    ahb_clk_in,
    input  logic    ahb_rstn_in,
    input  logic    hready,
    output addr_t   haddr,
    output trans_e  htrans,
    output burst_e  hburst,
    output size_t   hsize,
    output logic    hwrite,
    cmd_if.dst      cmd,
    beat_if.seq     beat
);

    seq_state_e state;
    logic [3:0] beats_left;    // beats after the one on the bus.
    logic       reject_q;
    addr_t      step;
    addr_t      incr_addr;
    addr_t      wrap_mask;
    addr_t      next_addr;

    ////////////////////
    // address generation.
    assign step      = addr_t'(1) << hsize;
    assign incr_addr = haddr + step;
    assign wrap_mask = (addr_t'(burst_len(hburst)) << hsize) - addr_t'(1);    // block of beats x bytes.
    assign next_addr = (hburst inside {BURST_WRAP4, BURST_WRAP8, BURST_WRAP16}) ?
                       ((haddr & ~wrap_mask) | (incr_addr & wrap_mask)) : incr_addr;

    assign beat.accept = (htrans != TRANS_IDLE) && hready;
    assign beat.write  = hwrite;
    assign beat.last   = (beats_left == 4'd0);
    assign beat.reject = reject_q;

    ////////////////////
    // sequencer.
    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            state      <= ST_IDLE;
            htrans     <= TRANS_IDLE;
            haddr      <= '0;
            hburst     <= BURST_SINGLE;
            hsize      <= '0;
            hwrite     <= 1'b0;
            beats_left <= '0;
            reject_q   <= 1'b0;
            cmd.busy   <= 1'b0;
        end else begin
            reject_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd.valid) begin
                        cmd.busy <= 1'b1;
                        if (cmd.reject) begin
                            reject_q <= 1'b1;    // error response without a bus cycle.
                            state    <= ST_DRAIN;
                        end else begin
                            haddr      <= cmd.cmd.addr;
                            hburst     <= cmd.cmd.burst;
                            hsize      <= cmd.cmd.size;
                            hwrite     <= cmd.cmd.write;
                            htrans     <= TRANS_NONSEQ;
                            beats_left <= 4'(burst_len(cmd.cmd.burst) - 1);
                            state      <= ST_ADDR;
                        end
                    end
                end
                ST_ADDR: begin
                    if (beat.abort) begin
                        htrans <= TRANS_IDLE;
                        state  <= ST_DRAIN;
                    end else if (hready) begin
                        if (beats_left == 4'd0) begin
                            htrans <= TRANS_IDLE;
                            state  <= ST_DRAIN;
                        end else begin
                            haddr      <= next_addr;
                            htrans     <= TRANS_SEQ;
                            beats_left <= beats_left - 4'd1;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (beat.done) begin
                        cmd.busy <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    htrans <= TRANS_IDLE;
                    state  <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/data_phase.sv ====
////////////////////
// tracks the one beat in its data phase and answers the client.
// errors are taken as single-cycle hresp with hready high.
// a beat accepted together with an error, or a timed-out beat,
// still finishes on the bus but gives no response.
////////////////////

`timescale 1ns/10ps

`include "ahb_defs.svh"

module data_phase
    import ahb_pkg::*;
(
    input  logic  ahb_clk_in,
    input  logic  ahb_rstn_in,
    input  logic  hready,
    input  logic  hresp,
    input  data_t hrdata,
    input  data_t wdata,
    output data_t hwdata,
    output logic  wdata_pop,
    output logic  resp_valid,
    output logic  resp_error,
    output data_t rdata,
    beat_if.dat   beat
);

    localparam int WAIT_W = $clog2(`AHB_WAIT_TIMEOUT + 1);

    logic              act_q;     // a beat is in its data phase.
    logic              drop_q;    // its response is suppressed.
    logic              wr_q;
    logic              last_q;
    logic              done_q;
    logic [WAIT_W-1:0] wait_cnt;
    logic              live;
    logic              bus_err;
    logic              tmo;

    assign live    = act_q & ~drop_q;
    assign bus_err = live & hready & hresp;
    assign tmo     = live & ~hready & (wait_cnt == WAIT_W'(`AHB_WAIT_TIMEOUT - 1));

    assign beat.abort = bus_err | tmo;
    assign beat.done  = done_q;
    assign wdata_pop  = beat.accept & beat.write;

    ////////////////////
    // beat tracking and responses.
    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            act_q      <= 1'b0;
            drop_q     <= 1'b0;
            wait_cnt   <= '0;
            resp_valid <= 1'b0;
            resp_error <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            resp_error <= 1'b0;
            done_q     <= 1'b0;
            if (beat.reject) begin
                resp_valid <= 1'b1;
                resp_error <= 1'b1;
                done_q     <= 1'b1;
            end
            if (hready) begin
                if (live) begin
                    resp_valid <= 1'b1;
                    resp_error <= hresp;
                    done_q     <= last_q | hresp;    // an error closes the burst.
                end
                act_q    <= beat.accept;
                drop_q   <= bus_err;
                wait_cnt <= '0;
            end else if (tmo) begin
                resp_valid <= 1'b1;
                resp_error <= 1'b1;
                done_q     <= 1'b1;
                drop_q     <= 1'b1;    // keep tracking until the slave lets go.
            end else if (live) begin
                wait_cnt <= wait_cnt + WAIT_W'(1);
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (beat.accept) begin
            wr_q   <= beat.write;
            last_q <= beat.last;
        end
        if (wdata_pop) begin
            hwdata <= wdata;    // held through the whole data phase.
        end
        if (hready && live && !wr_q) begin
            rdata <= hrdata;
        end
    end

endmodule

// ==== design/ahb_master_top.sv ====
////////////////////
// AHB-Lite burst master, one command at a time.
// no BUSY transfers, no protection or strobe outputs.
// the client must hold wdata valid in every wdata_pop cycle.
////////////////////

`timescale 1ns/10ps

module ahb_master_top
    import ahb_pkg::*;
(
    input  logic   ahb_clk_in,
    input  logic   ahb_rstn_in,

    // client side.
    input  logic   cmd_valid,
    input  addr_t  cmd_addr,
    input  burst_e cmd_burst,
    input  size_t  cmd_size,
    input  logic   cmd_write,
    input  data_t  wdata,
    output logic   cmd_busy,
    output logic   wdata_pop,
    output logic   resp_valid,
    output logic   resp_error,
    output data_t  rdata,

    // bus side.
    output addr_t  haddr,
    output trans_e htrans,
    output burst_e hburst,
    output size_t  hsize,
    output logic   hwrite,
    output data_t  hwdata,
    input  data_t  hrdata,
    input  logic   hready,
    input  logic   hresp
);

    cmd_if  u_cmd_if ();
    beat_if u_beat_if ();

    req_check u_req_check (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .cmd_valid   (cmd_valid),
        .cmd_addr    (cmd_addr),
        .cmd_burst   (cmd_burst),
        .cmd_size    (cmd_size),
        .cmd_write   (cmd_write),
        .cmd_busy    (cmd_busy),
        .cmd         (u_cmd_if.src)
    );

    burst_seq u_burst_seq (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .hready      (hready),
        .haddr       (haddr),
        .htrans      (htrans),
        .hburst      (hburst),
        .hsize       (hsize),
        .hwrite      (hwrite),
        .cmd         (u_cmd_if.dst),
        .beat        (u_beat_if.seq)
    );

    data_phase u_data_phase (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .hready      (hready),
        .hresp       (hresp),
        .hrdata      (hrdata),
        .wdata       (wdata),
        .hwdata      (hwdata),
        .wdata_pop   (wdata_pop),
        .resp_valid  (resp_valid),
        .resp_error  (resp_error),
        .rdata       (rdata),
        .beat        (u_beat_if.dat)
    );

endmodule

// ==== testbench/tb_ahb_slave.sv ====
////////////////////
// AHB-Lite memory slave for the master testbench, 4 KB of words.
// errors are one cycle of hresp with hready high.
// a stall address holds hready low past the master timeout.
////////////////////

`timescale 1ns/10ps

`include "ahb_defs.svh"

module tb_ahb_slave
    import ahb_pkg::*;
#(
    parameter int MAX_WAIT = 3
) (
    input  logic   ahb_clk_in,
    input  logic   ahb_rstn_in,
    input  addr_t  haddr,
    input  trans_e htrans,
    input  logic   hwrite,
    input  data_t  hwdata,
    output data_t  hrdata,
    output logic   hready,
    output logic   hresp,
    input  logic   rand_wait,
    input  logic   err_en,
    input  addr_t  err_addr,
    input  logic   stall_en,
    input  addr_t  stall_addr
);

    localparam int STALL_CYCLES = `AHB_WAIT_TIMEOUT + 6;

    data_t  mem [1024];
    integer seed;
    logic   dp_act;    // a data phase is open.
    addr_t  dp_addr;
    logic   dp_write;
    int     wait_left;
    logic   hit_err;

    assign hit_err = err_en && (dp_addr == err_addr);
    assign hready  = !dp_act || (wait_left == 0);
    assign hresp   = dp_act && (wait_left == 0) && hit_err;
    assign hrdata  = mem[dp_addr[11:2]];

    initial begin
        seed = 32'ha650a772;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = data_t'(i << 2) ^ 32'hc3c3_0000;    // byte address based.
        end
    end

    always @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            dp_act    <= 1'b0;
            dp_addr   <= '0;
            dp_write  <= 1'b0;
            wait_left <= 0;
        end else if (hready) begin
            if (dp_act && dp_write && !hit_err) begin
                mem[dp_addr[11:2]] <= hwdata;
            end
            dp_act   <= (htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ);
            dp_addr  <= haddr;
            dp_write <= hwrite;
            if (stall_en && haddr == stall_addr) begin
                wait_left <= STALL_CYCLES;
            end else if (rand_wait) begin
                wait_left <= $unsigned($random(seed)) % (MAX_WAIT + 1);
            end else begin
                wait_left <= 0;
            end
        end else begin
            wait_left <= wait_left - 1;
        end
    end

endmodule

// ==== testbench/tb_top.sv ====
////////////////////
// testbench for the AHB-Lite burst master.
// all legal bursts use word size, reads only hit written words.
////////////////////

`timescale 1ns/10ps

`include "ahb_defs.svh"

module tb_top
    import ahb_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int SLAVE_MAX_WAIT = 3;
    localparam int BEAT_BUDGET    = 400;
    localparam int CMD_BUDGET     = 60;
    localparam int WATCHDOG_NS    = (BEAT_BUDGET * (SLAVE_MAX_WAIT + 2) +
                                     CMD_BUDGET * (`AHB_WAIT_TIMEOUT + 14)) * CLK_PERIOD;

    logic   ahb_clk_in;
    logic   ahb_rstn_in;
    logic   cmd_valid;
    addr_t  cmd_addr;
    burst_e cmd_burst;
    size_t  cmd_size;
    logic   cmd_write;
    data_t  wdata;
    logic   cmd_busy;
    logic   wdata_pop;
    logic   resp_valid;
    logic   resp_error;
    data_t  rdata;
    addr_t  haddr;
    trans_e htrans;
    burst_e hburst;
    size_t  hsize;
    logic   hwrite;
    data_t  hwdata;
    data_t  hrdata;
    logic   hready;
    logic   hresp;
    logic   rand_wait;
    logic   err_en;
    addr_t  err_addr;
    logic   stall_en;
    addr_t  stall_addr;

    int     errors;
    int     pop_count;
    integer seed;
    burst_e cur_burst;    // control of the command on the bus.
    size_t  cur_size;
    logic   cur_write;
    data_t  shadow [addr_t];
    data_t  wr_words [$];
    addr_t  exp_addr [$];
    trans_e exp_trans [$];
    logic   exp_err [$];
    logic   exp_chk [$];    // response carries read data to compare.
    data_t  exp_data [$];

    ahb_master_top UUT (.*);

    tb_ahb_slave #(.MAX_WAIT(SLAVE_MAX_WAIT)) u_slave (.*);

    always #(CLK_PERIOD / 2) ahb_clk_in = ~ahb_clk_in;

    ////////////////////
    // reference rules.
    function automatic int beats_of(burst_e burst);
        case (burst)
            BURST_WRAP4, BURST_INCR4:   return 4;
            BURST_WRAP8, BURST_INCR8:   return 8;
            BURST_WRAP16, BURST_INCR16: return 16;
            default:                    return 1;
        endcase
    endfunction

    function automatic addr_t next_beat_addr(addr_t start, burst_e burst, size_t size, int beat);
        addr_t bytes;
        addr_t block;
        addr_t base;
        bytes = addr_t'(1) << size;
        if (burst == BURST_WRAP4 || burst == BURST_WRAP8 || burst == BURST_WRAP16) begin
            block = bytes * addr_t'(beats_of(burst));    // wrap inside an aligned block.
            base  = start - (start % block);
            return base + ((start - base + addr_t'(beat) * bytes) % block);
        end
        return start + addr_t'(beat) * bytes;
    endfunction

    function automatic bit cmd_is_legal(addr_t a, burst_e burst, size_t size);
        addr_t bytes;
        addr_t last;
        bytes = addr_t'(1) << size;
        last  = a + bytes * addr_t'(beats_of(burst)) - 1;
        if (bytes * 8 > `AHB_DATA_WIDTH) return 0;
        if (a % bytes != 0) return 0;
        if (burst == BURST_INCR) return 0;
        if ((burst == BURST_INCR4 || burst == BURST_INCR8 || burst == BURST_INCR16) &&
            (a >> `AHB_BOUND_BITS) != (last >> `AHB_BOUND_BITS)) return 0;
        return 1;
    endfunction

    ////////////////////
    // compare tasks.
    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_trans(input string name, input trans_e got, input trans_e exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_burst(input string name, input burst_e got, input burst_e exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input size_t got, input size_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    ////////////////////
    // bus and response monitor, sampled at the falling edge.
    always @(negedge ahb_clk_in) begin
        if (ahb_rstn_in) begin
            if (htrans != TRANS_IDLE && hready) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("address phase at %h while no beat was expected", haddr);
                end else begin
                    check_addr("haddr", haddr, exp_addr.pop_front());
                    check_trans("htrans", htrans, exp_trans.pop_front());
                    check_burst("hburst", hburst, cur_burst);
                    check_size("hsize", hsize, cur_size);
                    check_flag("hwrite", hwrite, cur_write);
                end
            end
            if (resp_valid) begin
                if (exp_err.size() == 0) begin
                    errors++;
                    $display("response arrived while none was expected");
                end else begin
                    check_flag("resp_error", resp_error, exp_err.pop_front());
                    if (exp_chk.pop_front()) begin
                        check_data("rdata", rdata, exp_data.pop_front());
                    end else begin
                        void'(exp_data.pop_front());
                    end
                end
            end
        end
    end

    // client write words, advanced after each pop.
    always @(negedge ahb_clk_in) begin : feed_wdata
        logic popped;
        popped = ahb_rstn_in && (wdata_pop === 1'b1);
        @(posedge ahb_clk_in);
        #1;
        if (popped) begin
            pop_count++;
            if (wr_words.size() != 0) begin
                check_data("hwdata", hwdata, wr_words.pop_front());
            end else begin
                errors++;
                $display("wdata_pop with no write word queued");
            end
        end
        wdata = (wr_words.size() != 0) ? wr_words[0] : '0;
    end

    ////////////////////
    // stimulus.
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((exp_err.size() != 0 || cmd_busy) && cycles < 200) begin
            @(posedge ahb_clk_in);
            #1;
            cycles++;
        end
        if (cycles >= 200) begin
            errors++;
            $display("command did not complete within 200 cycles");
        end
    endtask

    // fail_beat below zero means a clean burst. on_bus marks a slave error,
    // which lets the next address phase through in the same cycle.
    task automatic run_cmd(input addr_t a, input burst_e b, input size_t s, input logic w,
                           input int fail_beat, input bit on_bus);
        bit    legal;
        int    len;
        int    pops;
        addr_t ad;
        data_t word;
        legal = cmd_is_legal(a, b, s);
        len   = beats_of(b);
        pops  = pop_count;
        if (!legal) begin
            exp_err.push_back(1'b1);
            exp_chk.push_back(1'b0);
            exp_data.push_back('0);
        end else begin
            for (int i = 0; i < len; i++) begin
                ad = next_beat_addr(a, b, s, i);
                if (fail_beat < 0 || i <= fail_beat || (on_bus && i == fail_beat + 1)) begin
                    exp_addr.push_back(ad);
                    exp_trans.push_back(i == 0 ? TRANS_NONSEQ : TRANS_SEQ);
                end
                if (fail_beat < 0 || i < fail_beat) begin
                    exp_err.push_back(1'b0);
                    exp_chk.push_back(!w);
                    exp_data.push_back(w ? '0 : shadow[ad]);
                    if (w) begin
                        word = $random(seed);
                        wr_words.push_back(word);
                        shadow[ad] = word;
                    end
                end else if (i == fail_beat) begin
                    exp_err.push_back(1'b1);
                    exp_chk.push_back(1'b0);
                    exp_data.push_back('0);
                end
            end
        end
        cur_burst = b;
        cur_size  = s;
        cur_write = w;
        @(posedge ahb_clk_in);
        #1;
        cmd_valid = 1'b1;
        cmd_addr  = a;
        cmd_burst = b;
        cmd_size  = s;
        cmd_write = w;
        @(posedge ahb_clk_in);    // master is idle, so this edge takes the command.
        #1;
        cmd_valid = 1'b0;
        wait_idle();
        check_count("address phases left", exp_addr.size(), 0);
        if (legal && fail_beat < 0) begin
            check_count("wdata_pop count", pop_count - pops, w ? len : 0);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        burst_e kinds [6];
        burst_e b;
        addr_t  a;
        kinds = '{BURST_INCR4, BURST_INCR8, BURST_INCR16,
                  BURST_WRAP4, BURST_WRAP8, BURST_WRAP16};
        seed = 32'ha650a772;
        errors = 0;
        pop_count = 0;
        ahb_clk_in = 1'b0;
        ahb_rstn_in = 1'b0;
        cmd_valid = 1'b0;
        cmd_addr = '0;
        cmd_burst = BURST_SINGLE;
        cmd_size = '0;
        cmd_write = 1'b0;
        wdata = '0;
        rand_wait = 1'b0;
        err_en = 1'b0;
        err_addr = '0;
        stall_en = 1'b0;
        stall_addr = '0;
        repeat (5) @(posedge ahb_clk_in);
        #1 ahb_rstn_in = 1'b1;
        @(posedge ahb_clk_in);

        run_cmd(32'h010, BURST_SINGLE, 3'd2, 1'b1, -1, 0);    // single write then read.
        run_cmd(32'h010, BURST_SINGLE, 3'd2, 1'b0, -1, 0);
        rand_wait = 1'b1;

        run_cmd(32'h000, BURST_INCR4, 3'd2, 1'b1, -1, 0);
        run_cmd(32'h000, BURST_INCR4, 3'd2, 1'b0, -1, 0);
        run_cmd(32'h040, BURST_INCR8, 3'd2, 1'b1, -1, 0);
        run_cmd(32'h040, BURST_INCR8, 3'd2, 1'b0, -1, 0);
        run_cmd(32'h080, BURST_INCR16, 3'd2, 1'b1, -1, 0);
        run_cmd(32'h080, BURST_INCR16, 3'd2, 1'b0, -1, 0);

        run_cmd(32'h208, BURST_WRAP4, 3'd2, 1'b1, -1, 0);     // wraps start mid-block.
        run_cmd(32'h208, BURST_WRAP4, 3'd2, 1'b0, -1, 0);
        run_cmd(32'h31c, BURST_WRAP8, 3'd2, 1'b1, -1, 0);
        run_cmd(32'h31c, BURST_WRAP8, 3'd2, 1'b0, -1, 0);
        run_cmd(32'h4a4, BURST_WRAP16, 3'd2, 1'b1, -1, 0);
        run_cmd(32'h4a4, BURST_WRAP16, 3'd2, 1'b0, -1, 0);

        run_cmd(32'h102, BURST_INCR4, 3'd2, 1'b0, -1, 0);     // misaligned.
        run_cmd(32'h100, BURST_SINGLE, 3'd3, 1'b0, -1, 0);    // 64-bit size.
        run_cmd(32'h3f8, BURST_INCR4, 3'd2, 1'b1, -1, 0);     // crosses 1 KB.
        run_cmd(32'h100, BURST_INCR, 3'd2, 1'b0, -1, 0);

        run_cmd(32'h600, BURST_INCR8, 3'd2, 1'b1, -1, 0);
        err_addr = 32'h608;
        err_en = 1'b1;
        run_cmd(32'h600, BURST_INCR8, 3'd2, 1'b0, 2, 1);      // slave error on beat 3.
        err_en = 1'b0;

        for (int i = 0; i < 6; i++) begin
            b = kinds[$unsigned($random(seed)) % 6];
            a = 32'h800 + ($unsigned($random(seed)) & 32'h1fc);
            run_cmd(a, b, 3'd2, 1'b1, -1, 0);
            run_cmd(a, b, 3'd2, 1'b0, -1, 0);
        end

        stall_addr = 32'hc00;
        stall_en = 1'b1;
        run_cmd(32'hc00, BURST_SINGLE, 3'd2, 1'b0, 0, 0);     // ready timeout.
        stall_en = 1'b0;
        run_cmd(32'h010, BURST_SINGLE, 3'd2, 1'b0, -1, 0);

        repeat (4) @(posedge ahb_clk_in);
        $display("errors: %0d, unanswered responses: %0d", errors, exp_err.size());
        if (errors == 0 && exp_err.size() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/ahb_pkg.sv
common/master_pkg.sv
common/cmd_if.sv
common/beat_if.sv
design/req_check.sv
burst_seq/burst_seq.sv
design/data_phase.sv
design/ahb_master_top.sv
testbench/tb_ahb_slave.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the AHB-Lite master testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f all.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"
